//--- sim.f
source/tile_pkg.sv
source/tile_config.sv
source/inst_mem.sv
source/inst_fetch.sv
source/regfile.sv
source/exec_stage.sv
source/ldst_unit.sv
source/tile_top.sv
sim/tile_sva.sv
sim/tile_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tile_tb -f sim.f -o tile_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/tile_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0

//--- sim/tile_tb.sv
module tile_tb;

  // operand codes beyond the register file
  localparam int W = 12;
  localparam int Z = 13;

  logic                Clk;
  logic                Reset;
  tile_pkg::prog_wr_t  prog_wr;
  logic                start;
  tile_pkg::data_t     west;
  logic                mem_gnt;
  tile_pkg::data_t     mem_rdata;
  tile_pkg::mem_req_t  mem_req;
  logic                mem_valid;
  tile_pkg::data_t     result;
  logic                cond;
  logic                done;
  logic                running;
  tile_pkg::perf_t     perf;

  tile_pkg::inst_t prog [tile_pkg::IMEM_DEPTH];
  int              prog_len;
  tile_pkg::data_t data_mem [16];
  tile_pkg::data_t model_mem [16];
  tile_pkg::data_t model_regs [8];
  logic            model_flag;
  tile_pkg::data_t model_result;
  int              model_issued;
  int              model_extra;
  int              stall_seen;
  int              grant_delay;

  tile_top u_tile_top (
    .Clk         (Clk),
    .Reset       (Reset),
    .prog_wr_i   (prog_wr),
    .start_i     (start),
    .west_i      (west),
    .mem_gnt_i   (mem_gnt),
    .mem_rdata_i (mem_rdata),
    .mem_req_o   (mem_req),
    .mem_valid_o (mem_valid),
    .result_o    (result),
    .cond_o      (cond),
    .done_o      (done),
    .running_o   (running),
    .perf_o      (perf)
  );

  initial begin
    Clk = 1'b0;
    forever #5 Clk = ~Clk;
  end

  //////////////////////////////////////////////////////////////////////
  // memory responder, grant after 0..4 cycles
  //////////////////////////////////////////////////////////////////////

  initial begin
    grant_delay = -1;
    forever begin
      @(posedge Clk);
      #1;
      if (mem_gnt) begin
        mem_gnt = 1'b0;
      end else if (mem_valid) begin
        if (grant_delay < 0) begin
          grant_delay = $urandom_range(4, 0);
        end
        if (grant_delay == 0) begin
          mem_gnt     = 1'b1;
          mem_rdata   = data_mem[mem_req.addr[3:0]];
          grant_delay = -1;
          if (mem_req.we) begin
            data_mem[mem_req.addr[3:0]] = mem_req.wdata;
          end
        end else begin
          grant_delay--;
        end
      end
    end
  end

  // pending request without grant, mid-cycle
  always @(negedge Clk) begin
    if (mem_valid && !mem_gnt) begin
      stall_seen++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(string name, tile_pkg::data_t exp, tile_pkg::data_t act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  function automatic tile_pkg::inst_t encode(tile_pkg::op_e op, int dst, int s0, int s1);
    tile_pkg::inst_t ins;
    ins.spare  = '0;
    ins.opcode = op;
    ins.dst    = dst[2:0];
    ins.src0   = s0[3:0];
    ins.src1   = s1[3:0];
    return ins;
  endfunction

  task automatic append_inst(tile_pkg::inst_t ins);
    prog[prog_len] = ins;
    prog_len++;
  endtask

  function automatic tile_pkg::data_t src_value(tile_pkg::src_sel_t sel, tile_pkg::data_t w);
    tile_pkg::data_t val;
    val = '0;
    if (sel < 8) begin
      val = model_regs[sel[2:0]];
    end else if (sel == W) begin
      val = w;
    end
    return val;
  endfunction

  task automatic write_reg(tile_pkg::reg_addr_t dst, tile_pkg::data_t val);
    model_regs[dst] = val;
    model_result    = val;
  endtask

  // instruction-level reference, one instruction per step
  task automatic run_model(tile_pkg::data_t w);
    int              pc;
    int              steps;
    logic            halted;
    tile_pkg::inst_t ins;
    tile_pkg::data_t a;
    tile_pkg::data_t b;
    pc = 0;
    steps = 0;
    halted = 1'b0;
    model_issued = 0;
    model_extra = 0;
    while (!halted && steps < 256) begin
      ins = prog[pc];
      a = src_value(ins.src0, w);
      b = src_value(ins.src1, w);
      steps++;
      pc = (pc + 1) % 64;
      if (ins.opcode != tile_pkg::OP_EXIT) begin
        model_issued++;
      end
      case (ins.opcode)
        tile_pkg::OP_ADD: write_reg(ins.dst, a + b);
        tile_pkg::OP_SUB: write_reg(ins.dst, a - b);
        tile_pkg::OP_AND: write_reg(ins.dst, a & b);
        tile_pkg::OP_OR:  write_reg(ins.dst, a | b);
        tile_pkg::OP_XOR: write_reg(ins.dst, a ^ b);
        tile_pkg::OP_SLL: write_reg(ins.dst, a << b[4:0]);
        tile_pkg::OP_SRL: write_reg(ins.dst, a >> b[4:0]);
        tile_pkg::OP_MOV: write_reg(ins.dst, a);
        tile_pkg::OP_SLT: begin
          model_flag = $signed(a) < $signed(b);
          write_reg(ins.dst, {31'b0, model_flag});
        end
        tile_pkg::OP_LD:  write_reg(ins.dst, model_mem[b[3:0]]);
        tile_pkg::OP_ST:  model_mem[b[3:0]] = a;
        tile_pkg::OP_NOP: model_extra += (ins.src1 > 1) ? int'(ins.src1) - 1 : 0;
        tile_pkg::OP_JMP: pc = int'({ins.src0, ins.src1}) % 64;
        tile_pkg::OP_BRC: pc = model_flag ? int'({ins.src0, ins.src1}) % 64 : pc;
        tile_pkg::OP_EXIT: halted = 1'b1;
        default: ;
      endcase
    end
    if (!halted) begin
      $display("reference model never reached EXIT");
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // load, start, wait, compare
  //////////////////////////////////////////////////////////////////////

  task automatic run_program(string name, tile_pkg::data_t w, bit restart, bit check_cycles);
    int cnt;
    run_model(w);
    for (int i = 0; i < prog_len; i++) begin
      @(posedge Clk);
      #1;
      prog_wr = '{valid: 1'b1, addr: tile_pkg::pc_t'(i), inst: prog[i]};
    end
    @(posedge Clk);
    #1;
    prog_wr.valid = 1'b0;
    west = w;
    start = 1'b1;
    stall_seen = 0;
    @(posedge Clk);
    #1;
    start = 1'b0;
    if (restart) begin
      // a second start mid-run must be ignored
      repeat (3) @(posedge Clk);
      #1;
      start = 1'b1;
      @(posedge Clk);
      #1;
      start = 1'b0;
    end
    cnt = 0;
    while (!done) begin
      @(posedge Clk);
      #1;
      cnt++;
      if (cnt > 2000) begin
        $display("timeout waiting for done in %s", name);
        $display("Test FAILED");
        $fatal(1);
      end
    end
    check({name, " result"}, model_result, result);
    check({name, " cond"}, {31'b0, model_flag}, {31'b0, cond});
    check({name, " running"}, 0, {31'b0, running});
    check({name, " ins_count"}, model_issued, perf.ins_count);
    check({name, " stall_count"}, stall_seen, perf.stall_count);
    if (check_cycles) begin
      check({name, " cycle_count"}, model_issued + model_extra + 2, perf.cycle_count);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(81));
    Reset = 1'b0;
    prog_wr = '0;
    start = 1'b0;
    west = '0;
    mem_gnt = 1'b0;
    mem_rdata = '0;
    stall_seen = 0;
    model_flag = 1'b0;
    model_result = '0;
    for (int i = 0; i < 8; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < 16; i++) begin
      data_mem[i]  = 32'h0101_0000 * i + 32'h55 * (i + 1);
      model_mem[i] = data_mem[i];
    end
    repeat (16) @(posedge Clk);
    #1;
    Reset = 1'b1;
    check("reset running", 0, {31'b0, running});
    check("reset done", 0, {31'b0, done});
    check("reset mem_valid", 0, {31'b0, mem_valid});
    check("reset result", 0, result);
    check("reset cond", 0, {31'b0, cond});
    check("reset perf", 0, perf.ins_count | perf.cycle_count | perf.stall_count);

    // arithmetic on registers and west, folded into r0
    prog_len = 0;
    append_inst(encode(tile_pkg::OP_MOV, 1, W, Z));
    append_inst(encode(tile_pkg::OP_ADD, 2, 1, 1));
    append_inst(encode(tile_pkg::OP_SUB, 3, 2, W));
    append_inst(encode(tile_pkg::OP_AND, 4, 2, 3));
    append_inst(encode(tile_pkg::OP_OR, 5, 4, W));
    append_inst(encode(tile_pkg::OP_XOR, 6, 5, 2));
    append_inst(encode(tile_pkg::OP_SLT, 7, Z, 1));
    append_inst(encode(tile_pkg::OP_ADD, 7, 7, 7));
    append_inst(encode(tile_pkg::OP_SLL, 4, 6, 7));
    append_inst(encode(tile_pkg::OP_SRL, 5, 6, 7));
    append_inst(encode(tile_pkg::OP_XOR, 1, 4, 5));
    append_inst(encode(tile_pkg::OP_XOR, 1, 1, 3));
    append_inst(encode(tile_pkg::OP_MOV, 0, 1, Z));
    append_inst(encode(tile_pkg::OP_EXIT, 0, 0, 0));
    run_program("arith", 32'h1234_5678, 1'b0, 1'b1);

    // branch taken, branch not taken, jump
    prog_len = 0;
    append_inst(encode(tile_pkg::OP_MOV, 1, W, Z));
    append_inst(encode(tile_pkg::OP_SLT, 2, Z, 1));
    append_inst(encode(tile_pkg::OP_MOV, 3, 1, Z));
    append_inst(encode(tile_pkg::OP_BRC, 0, 0, 6));
    append_inst(encode(tile_pkg::OP_XOR, 1, 1, 1));
    append_inst(encode(tile_pkg::OP_EXIT, 0, 0, 0));
    append_inst(encode(tile_pkg::OP_SLT, 2, 1, Z));
    append_inst(encode(tile_pkg::OP_MOV, 3, 1, Z));
    append_inst(encode(tile_pkg::OP_BRC, 0, 0, 4));
    append_inst(encode(tile_pkg::OP_ADD, 4, 1, 1));
    append_inst(encode(tile_pkg::OP_JMP, 0, 0, 12));
    append_inst(encode(tile_pkg::OP_XOR, 4, 4, 1));
    append_inst(encode(tile_pkg::OP_MOV, 0, 4, Z));
    append_inst(encode(tile_pkg::OP_EXIT, 0, 0, 0));
    run_program("branch", 32'd5, 1'b0, 1'b1);

    // loads and stores under random grant delays
    prog_len = 0;
    append_inst(encode(tile_pkg::OP_MOV, 1, W, Z));
    append_inst(encode(tile_pkg::OP_LD, 2, Z, 1));
    append_inst(encode(tile_pkg::OP_ADD, 3, 1, 1));
    append_inst(encode(tile_pkg::OP_ST, 0, 2, 3));
    append_inst(encode(tile_pkg::OP_LD, 4, Z, 3));
    append_inst(encode(tile_pkg::OP_LD, 5, Z, 1));
    append_inst(encode(tile_pkg::OP_ADD, 6, 4, 5));
    append_inst(encode(tile_pkg::OP_ST, 0, 6, 1));
    append_inst(encode(tile_pkg::OP_LD, 0, Z, 1));
    append_inst(encode(tile_pkg::OP_EXIT, 0, 0, 0));
    for (int r = 0; r < 3; r++) begin
      run_program("memory", 32'd3 + r, r == 0, 1'b0);
      for (int i = 0; i < 16; i++) begin
        check("memory word", model_mem[i], data_mem[i]);
      end
    end

    // nop repeat, also a second run after a loaded one
    prog_len = 0;
    append_inst(encode(tile_pkg::OP_MOV, 1, W, Z));
    append_inst(encode(tile_pkg::OP_NOP, 0, 0, 5));
    append_inst(encode(tile_pkg::OP_ADD, 2, 1, 1));
    append_inst(encode(tile_pkg::OP_NOP, 0, 0, 1));
    append_inst(encode(tile_pkg::OP_EXIT, 0, 0, 0));
    run_program("nop", 32'h0000_0321, 1'b0, 1'b1);
    run_program("nop rerun", 32'h0000_0777, 1'b0, 1'b1);

    $display("Test OK");
    $finish;
  end

endmodule

//--- sim/tile_sva.sv
module tile_sva (
  input  logic                Clk,
  input  logic                Reset,
  input  logic                start_i,
  input  logic                mem_gnt_i,
  input  tile_pkg::mem_req_t  mem_req_o,
  input  logic                mem_valid_o,
  input  logic                done_o,
  input  logic                running_o,
  input  tile_pkg::perf_t     perf_o
);

  //////////////////////////////////////////////////////////////////////
  // memory handshake
  //////////////////////////////////////////////////////////////////////

  // pending request keeps its payload and stays up
  a_req_stable: assert property (@(posedge Clk) disable iff (!Reset)
    mem_valid_o && !mem_gnt_i |=> mem_valid_o && $stable(mem_req_o))
    else $error("memory request changed before its grant");

  // counter frozen without a request, start clears it
  a_stall_quiet: assert property (@(posedge Clk) disable iff (!Reset)
    !mem_valid_o && !start_i |=> $stable(perf_o.stall_count))
    else $error("stall counter moved with no request out");

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  // done marks the edge where running drops
  a_done_fall: assert property (@(posedge Clk) disable iff (!Reset)
    done_o |-> !running_o && $past(running_o))
    else $error("done without running falling");

  a_done_pulse: assert property (@(posedge Clk) disable iff (!Reset)
    done_o |=> !done_o)
    else $error("done held longer than one cycle");

  // idle out of reset
  a_reset_idle: assert property (@(posedge Clk)
    !Reset || $rose(Reset) |-> !running_o && !mem_valid_o)
    else $error("tile active during or right after reset");

endmodule

bind tile_top tile_sva u_tile_sva (
  .Clk         (Clk),
  .Reset       (Reset),
  .start_i     (start_i),
  .mem_gnt_i   (mem_gnt_i),
  .mem_req_o   (mem_req_o),
  .mem_valid_o (mem_valid_o),
  .done_o      (done_o),
  .running_o   (running_o),
  .perf_o      (perf_o)
);

//--- source/tile_top.sv
module tile_top (
  input  logic                Clk,
  input  logic                Reset,
  input  tile_pkg::prog_wr_t  prog_wr_i,
  input  logic                start_i,
  input  tile_pkg::data_t     west_i,
  input  logic                mem_gnt_i,
  input  tile_pkg::data_t     mem_rdata_i,
  output tile_pkg::mem_req_t  mem_req_o,
  output logic                mem_valid_o,
  output tile_pkg::data_t     result_o,
  output logic                cond_o,
  output logic                done_o,
  output logic                running_o,
  output tile_pkg::perf_t     perf_o
);

  tile_pkg::prog_wr_t  imem_wr;
  tile_pkg::pc_t       pc;
  tile_pkg::inst_t     imem_inst;
  tile_pkg::inst_t     fetch_inst;
  logic                fetch_valid;
  logic                issue;
  logic                mem_stall;
  logic                exit_seen;
  tile_pkg::reg_addr_t raddr0;
  tile_pkg::reg_addr_t raddr1;
  tile_pkg::reg_addr_t waddr;
  logic                rf_we;
  tile_pkg::data_t     rf_wdata;
  tile_pkg::data_t     rdata0;
  tile_pkg::data_t     rdata1;
  tile_pkg::mem_op_t   mem_op;
  tile_pkg::ld_ret_t   ld_ret;

  //////////////////////////////////////////////////////////////////////
  // control and program store
  //////////////////////////////////////////////////////////////////////

  tile_config u_tile_config (
    .Clk         (Clk),
    .Reset       (Reset),
    .prog_wr_i   (prog_wr_i),
    .start_i     (start_i),
    .exit_i      (exit_seen),
    .issue_i     (issue),
    .mem_stall_i (mem_stall),
    .mem_valid_i (mem_valid_o),
    .mem_gnt_i   (mem_gnt_i),
    .imem_wr_o   (imem_wr),
    .run_o       (running_o),
    .done_o      (done_o),
    .perf_o      (perf_o)
  );

  inst_mem u_inst_mem (
    .Clk    (Clk),
    .wr_i   (imem_wr),
    .pc_i   (pc),
    .inst_o (imem_inst)
  );

  // fetch sits one instruction ahead of execute
  inst_fetch u_inst_fetch (
    .Clk           (Clk),
    .Reset         (Reset),
    .run_i         (running_o),
    .inst_i        (imem_inst),
    .cond_i        (cond_o),
    .stall_i       (mem_stall),
    .pc_o          (pc),
    .fetch_o       (fetch_inst),
    .fetch_valid_o (fetch_valid),
    .issue_o       (issue)
  );

  //////////////////////////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////////////////////////

  regfile u_regfile (
    .Clk      (Clk),
    .Reset    (Reset),
    .raddr0_i (raddr0),
    .raddr1_i (raddr1),
    .waddr_i  (waddr),
    .we_i     (rf_we),
    .wdata_i  (rf_wdata),
    .rdata0_o (rdata0),
    .rdata1_o (rdata1)
  );

  exec_stage u_exec_stage (
    .Clk      (Clk),
    .Reset    (Reset),
    .inst_i   (fetch_inst),
    .valid_i  (fetch_valid),
    .west_i   (west_i),
    .rdata0_i (rdata0),
    .rdata1_i (rdata1),
    .ld_ret_i (ld_ret),
    .stall_i  (mem_stall),
    .raddr0_o (raddr0),
    .raddr1_o (raddr1),
    .waddr_o  (waddr),
    .we_o     (rf_we),
    .wdata_o  (rf_wdata),
    .mem_op_o (mem_op),
    .result_o (result_o),
    .cond_o   (cond_o),
    .exit_o   (exit_seen)
  );

  // single outstanding request toward memory
  ldst_unit u_ldst_unit (
    .Clk         (Clk),
    .Reset       (Reset),
    .op_i        (mem_op),
    .mem_gnt_i   (mem_gnt_i),
    .mem_rdata_i (mem_rdata_i),
    .mem_req_o   (mem_req_o),
    .mem_valid_o (mem_valid_o),
    .stall_o     (mem_stall),
    .ld_ret_o    (ld_ret)
  );

endmodule

//--- source/ldst_unit.sv
module ldst_unit (
  input  logic                Clk,
  input  logic                Reset,
  input  tile_pkg::mem_op_t   op_i,
  input  logic                mem_gnt_i,
  input  tile_pkg::data_t     mem_rdata_i,
  output tile_pkg::mem_req_t  mem_req_o,
  output logic                mem_valid_o,
  output logic                stall_o,
  output tile_pkg::ld_ret_t   ld_ret_o
);

  logic               valid_q;
  logic               launch;
  logic               granted;
  tile_pkg::mem_req_t req_q;

  // new request only from idle
  assign launch  = !valid_q && op_i.valid;
  assign granted = valid_q && mem_gnt_i;

  //////////////////////////////////////////////////////////////////////
  // request handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge Reset) begin
    if (!Reset) begin
      valid_q <= 1'b0;
    end else if (valid_q) begin
      // drop on the grant edge
      if (mem_gnt_i) begin
        valid_q <= 1'b0;
      end
    end else if (op_i.valid) begin
      valid_q <= 1'b1;
    end
  end

  // held steady until granted
  always_ff @(posedge Clk) begin
    if (launch) begin
      req_q <= '{we: op_i.we, addr: op_i.addr, wdata: op_i.wdata};
    end
  end

  // hold fetch and execute until the grant cycle
  assign stall_o = op_i.valid && !granted;

  // load data taken straight from the bus in the grant cycle
  assign ld_ret_o = '{valid: granted && !req_q.we, data: mem_rdata_i};

  assign mem_req_o   = req_q;
  assign mem_valid_o = valid_q;

endmodule

//--- source/exec_stage.sv
module exec_stage (
  input  logic                 Clk,
  input  logic                 Reset,
  input  tile_pkg::inst_t      inst_i,
  input  logic                 valid_i,
  input  tile_pkg::data_t      west_i,
  input  tile_pkg::data_t      rdata0_i,
  input  tile_pkg::data_t      rdata1_i,
  input  tile_pkg::ld_ret_t    ld_ret_i,
  input  logic                 stall_i,
  output tile_pkg::reg_addr_t  raddr0_o,
  output tile_pkg::reg_addr_t  raddr1_o,
  output tile_pkg::reg_addr_t  waddr_o,
  output logic                 we_o,
  output tile_pkg::data_t      wdata_o,
  output tile_pkg::mem_op_t    mem_op_o,
  output tile_pkg::data_t      result_o,
  output logic                 cond_o,
  output logic                 exit_o
);

  tile_pkg::data_t op0;
  tile_pkg::data_t op1;
  tile_pkg::data_t alu_res;
  tile_pkg::data_t result_q;
  logic            cond_q;
  logic            lt;
  logic            is_alu;
  logic            is_ld;
  logic            is_st;
  logic            retire;

  // register, west input, or zero for any other code
  function automatic tile_pkg::data_t pick_src(tile_pkg::src_sel_t sel,
                                               tile_pkg::data_t rf,
                                               tile_pkg::data_t west);
    tile_pkg::data_t val;
    val = '0;
    if (sel < tile_pkg::src_sel_t'(tile_pkg::REG_COUNT)) begin
      val = rf;
    end else if (sel == tile_pkg::SRC_WEST) begin
      val = west;
    end
    return val;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // decode and operands
  //////////////////////////////////////////////////////////////////////

  assign raddr0_o = tile_pkg::reg_addr_t'(inst_i.src0);
  assign raddr1_o = tile_pkg::reg_addr_t'(inst_i.src1);
  assign waddr_o  = inst_i.dst;

  assign op0 = pick_src(inst_i.src0, rdata0_i, west_i);
  assign op1 = pick_src(inst_i.src1, rdata1_i, west_i);

  assign is_ld  = (inst_i.opcode == tile_pkg::OP_LD);
  assign is_st  = (inst_i.opcode == tile_pkg::OP_ST);
  assign is_alu = inst_i.opcode inside {tile_pkg::OP_ADD, tile_pkg::OP_SUB, tile_pkg::OP_AND,
                                        tile_pkg::OP_OR, tile_pkg::OP_XOR, tile_pkg::OP_SLL,
                                        tile_pkg::OP_SRL, tile_pkg::OP_SLT, tile_pkg::OP_MOV};

  // instruction finishes this cycle
  assign retire = valid_i && !stall_i;

  //////////////////////////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////////////////////////

  assign lt = $signed(op0) < $signed(op1);

  always_comb begin
    case (inst_i.opcode)
      tile_pkg::OP_ADD: alu_res = op0 + op1;
      tile_pkg::OP_SUB: alu_res = op0 - op1;
      tile_pkg::OP_AND: alu_res = op0 & op1;
      tile_pkg::OP_OR:  alu_res = op0 | op1;
      tile_pkg::OP_XOR: alu_res = op0 ^ op1;
      tile_pkg::OP_SLL: alu_res = op0 << op1[$clog2(tile_pkg::DATA_W)-1:0];
      tile_pkg::OP_SRL: alu_res = op0 >> op1[$clog2(tile_pkg::DATA_W)-1:0];
      tile_pkg::OP_SLT: alu_res = tile_pkg::data_t'(lt);
      tile_pkg::OP_MOV: alu_res = op0;
      default:          alu_res = '0;
    endcase
  end

  // loads write back only with the returned word
  assign we_o    = retire && (is_alu || (is_ld && ld_ret_i.valid));
  assign wdata_o = is_ld ? ld_ret_i.data : alu_res;

  // address from src1, store data from src0
  assign mem_op_o = '{
    valid: valid_i && (is_ld || is_st),
    we:    is_st,
    addr:  op1,
    wdata: op0
  };

  assign exit_o = valid_i && (inst_i.opcode == tile_pkg::OP_EXIT);

  // result and flag, flag touched by slt only
  always_ff @(posedge Clk or negedge Reset) begin
    if (!Reset) begin
      result_q <= '0;
      cond_q   <= 1'b0;
    end else begin
      if (we_o) begin
        result_q <= wdata_o;
      end
      if (retire && inst_i.opcode == tile_pkg::OP_SLT) begin
        cond_q <= lt;
      end
    end
  end

  assign result_o = result_q;
  assign cond_o   = cond_q;

endmodule

//--- source/regfile.sv
module regfile (
  input  logic                 Clk,
  input  logic                 Reset,
  input  tile_pkg::reg_addr_t  raddr0_i,
  input  tile_pkg::reg_addr_t  raddr1_i,
  input  tile_pkg::reg_addr_t  waddr_i,
  input  logic                 we_i,
  input  tile_pkg::data_t      wdata_i,
  output tile_pkg::data_t      rdata0_o,
  output tile_pkg::data_t      rdata1_o
);

  tile_pkg::data_t regs_q [tile_pkg::REG_COUNT];

  // single write port
  always_ff @(posedge Clk or negedge Reset) begin
    if (!Reset) begin
      for (int i = 0; i < tile_pkg::REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // two async read ports
  assign rdata0_o = regs_q[raddr0_i];
  assign rdata1_o = regs_q[raddr1_i];

endmodule

//--- source/inst_fetch.sv
module inst_fetch (
  input  logic               Clk,
  input  logic               Reset,
  input  logic               run_i,
  input  tile_pkg::inst_t    inst_i,
  input  logic               cond_i,
  input  logic               stall_i,
  output tile_pkg::pc_t      pc_o,
  output tile_pkg::inst_t    fetch_o,
  output logic               fetch_valid_o,
  output logic               issue_o
);

  tile_pkg::pc_t      pc_q;
  tile_pkg::pc_t      pc_next;
  tile_pkg::pc_t      target;
  tile_pkg::inst_t    fetch_q;
  tile_pkg::nop_cnt_t nop_cnt_q;
  logic               valid_q;
  logic               halted_q;
  logic               fetch_en;
  logic               nop_load;

  // target high bits come from src0
  assign target = tile_pkg::pc_t'({inst_i.src0, inst_i.src1});

  // no fetch during stall, nop hold or after exit
  assign fetch_en = run_i && !stall_i && !halted_q && (nop_cnt_q == '0);

  // nop of count n takes n cycles in all
  assign nop_load = (inst_i.opcode == tile_pkg::OP_NOP) && (inst_i.src1 > 4'd1);

  //////////////////////////////////////////////////////////////////////
  // next pc
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    pc_next = pc_q + 1'b1;
    if (inst_i.opcode == tile_pkg::OP_JMP) begin
      pc_next = target;
    end else if (inst_i.opcode == tile_pkg::OP_BRC && cond_i) begin
      // flag as registered by execute
      pc_next = target;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pc, valid bit, nop counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge Reset) begin
    if (!Reset) begin
      pc_q      <= '0;
      valid_q   <= 1'b0;
      halted_q  <= 1'b0;
      nop_cnt_q <= '0;
    end else if (!run_i) begin
      // idle tile restarts from address 0
      pc_q      <= '0;
      valid_q   <= 1'b0;
      halted_q  <= 1'b0;
      nop_cnt_q <= '0;
    end else if (!stall_i) begin
      // bubble into execute when nothing fetched
      valid_q <= fetch_en;
      if (fetch_en) begin
        pc_q     <= pc_next;
        halted_q <= (inst_i.opcode == tile_pkg::OP_EXIT);
        if (nop_load) begin
          nop_cnt_q <= tile_pkg::nop_cnt_t'(inst_i.src1 - 1'b1);
        end
      end else if (nop_cnt_q != '0) begin
        nop_cnt_q <= nop_cnt_q - 1'b1;
      end
    end
  end

  // fetch register payload
  always_ff @(posedge Clk) begin
    if (fetch_en) begin
      fetch_q <= inst_i;
    end
  end

  // one pulse per instruction leaving execute, exit excluded
  assign issue_o = valid_q && !stall_i && (fetch_q.opcode != tile_pkg::OP_EXIT);

  assign pc_o          = pc_q;
  assign fetch_o       = fetch_q;
  assign fetch_valid_o = valid_q;

endmodule

//--- source/inst_mem.sv
module inst_mem (
  input  logic                Clk,
  input  tile_pkg::prog_wr_t  wr_i,
  input  tile_pkg::pc_t       pc_i,
  output tile_pkg::inst_t     inst_o
);

  // program store, one instruction per pc
  tile_pkg::inst_t mem_q [tile_pkg::IMEM_DEPTH];

  // load port from the config block
  always_ff @(posedge Clk) begin
    if (wr_i.valid) begin
      mem_q[wr_i.addr] <= wr_i.inst;
    end
  end

  // fetch reads without a clock
  assign inst_o = mem_q[pc_i];

endmodule

//--- source/tile_config.sv
module tile_config (
  input  logic                Clk,
  input  logic                Reset,
  input  tile_pkg::prog_wr_t  prog_wr_i,
  input  logic                start_i,
  input  logic                exit_i,
  input  logic                issue_i,
  input  logic                mem_stall_i,
  input  logic                mem_valid_i,
  input  logic                mem_gnt_i,
  output tile_pkg::prog_wr_t  imem_wr_o,
  output logic                run_o,
  output logic                done_o,
  output tile_pkg::perf_t     perf_o
);

  logic            run_q;
  logic            done_q;
  logic            start_ok;
  logic            stall_pend;
  tile_pkg::perf_t perf_q;

  // start only counts while idle
  assign start_ok = start_i && !run_q;

  // request out and not yet granted
  assign stall_pend = mem_valid_i && !mem_gnt_i && mem_stall_i;

  // program writes blocked while running
  assign imem_wr_o = '{
    valid: prog_wr_i.valid && !run_q,
    addr:  prog_wr_i.addr,
    inst:  prog_wr_i.inst
  };

  //////////////////////////////////////////////////////////////////////
  // run flag and done pulse
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge Reset) begin
    if (!Reset) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      // one cycle, on the edge exit leaves execute
      done_q <= run_q && exit_i;
      if (start_ok) begin
        run_q <= 1'b1;
      end else if (exit_i) begin
        run_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // performance counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge Reset) begin
    if (!Reset) begin
      perf_q <= '0;
    end else if (start_ok) begin
      // fresh run, fresh numbers
      perf_q <= '0;
    end else if (run_q) begin
      perf_q.cycle_count <= perf_q.cycle_count + 1'b1;
      if (issue_i) begin
        perf_q.ins_count <= perf_q.ins_count + 1'b1;
      end
      if (stall_pend) begin
        perf_q.stall_count <= perf_q.stall_count + 1'b1;
      end
    end
  end

  assign run_o  = run_q;
  assign done_o = done_q;
  assign perf_o = perf_q;

endmodule

//--- source/tile_pkg.sv
package tile_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////////////////////////

  localparam int DATA_W     = 32;
  localparam int REG_COUNT  = 8;
  localparam int REG_AW     = $clog2(REG_COUNT);
  localparam int IMEM_DEPTH = 64;
  localparam int PC_W       = $clog2(IMEM_DEPTH);
  localparam int SRC_W      = 4;
  localparam int OP_W       = 6;
  // longest nop repeat that fits the src1 field
  localparam int NOP_MAX    = 15;

  typedef logic [DATA_W-1:0]                 data_t;
  typedef logic [REG_AW-1:0]                 reg_addr_t;
  typedef logic [PC_W-1:0]                   pc_t;
  typedef logic [SRC_W-1:0]                  src_sel_t;
  typedef logic [$clog2(NOP_MAX+1)-1:0]      nop_cnt_t;

  // codes 0..7 pick a register, this one the west neighbour
  localparam src_sel_t SRC_WEST = 4'd12;

  //////////////////////////////////////////////////////////////////////
  // instruction set
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [OP_W-1:0] {
    OP_NOP  = 6'h00,
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_XOR  = 6'h05,
    OP_SLL  = 6'h06,
    OP_SRL  = 6'h08,
    OP_LD   = 6'h07,
    OP_ST   = 6'h09,
    OP_SLT  = 6'h0A,
    OP_MOV  = 6'h0B,
    OP_BRC  = 6'h13,
    OP_JMP  = 6'h14,
    OP_EXIT = 6'h1F
  } op_e;

  // opcode in the low bits, jump target split over src0/src1
  typedef struct packed {
    logic [3:0] spare;
    src_sel_t   src1;
    src_sel_t   src0;
    reg_addr_t  dst;
    op_e        opcode;
  } inst_t;

  //////////////////////////////////////////////////////////////////////
  // port bundles
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  valid;
    pc_t   addr;
    inst_t inst;
  } prog_wr_t;

  typedef struct packed {
    logic  we;
    data_t addr;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    logic  we;
    data_t addr;
    data_t wdata;
  } mem_op_t;

  typedef struct packed {
    logic  valid;
    data_t data;
  } ld_ret_t;

  typedef struct packed {
    data_t ins_count;
    data_t cycle_count;
    data_t stall_count;
  } perf_t;

endpackage
